// File: addr_stream_pkg.sv
package addr_stream_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////
   localparam int ADDR_W   = 10;  // byte address.
   localparam int DATA_W   = 32;
   localparam int OFFSET_W = 2;   // byte offset inside a word.
   localparam int PERIOD_W = 8;
   localparam int DELAY_W  = 4;
   localparam int N_CH     = 2;   // stream channels.

   ////////////////////////////////////////
   // generator configuration
   ////////////////////////////////////////
   typedef struct packed {
      logic        [PERIOD_W-1:0] period;
      logic signed [ADDR_W-1:0]   incr;        // step inside the period.
      logic        [ADDR_W-1:0]   iterations;
      logic signed [ADDR_W-1:0]   shift;       // step between periods.
   } loop_cfg_t;

   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [PERIOD_W-1:0] duty;
      logic [DELAY_W-1:0]  delay;
      loop_cfg_t [2:0]     lvl;  // index 0 is the innermost loop.
   } gen_cfg_t;

   ////////////////////////////////////////
   // wishbone classic
   ////////////////////////////////////////
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

endpackage

// File: addr_gen.sv
module addr_gen (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                run_i,
   input  addr_stream_pkg::gen_cfg_t           cfg_i,
   output logic                                valid_o,
   input  logic                                ready_i,
   output logic [addr_stream_pkg::ADDR_W-1:0]  addr_o,
   output logic                                done_o
);

   localparam int AW = addr_stream_pkg::ADDR_W;
   localparam int PW = addr_stream_pkg::PERIOD_W;

   logic [addr_stream_pkg::DELAY_W-1:0] delay_q;  // cycles left before the first valid.

   logic [PW-1:0] per_q, per2_q, per3_q;
   logic [AW-1:0] iter_q, iter2_q, iter3_q;
   logic [AW-1:0] base2_q, base3_q;  // loop bases of the outer levels.

   logic          per_end, iter_end;
   logic          per2_end, iter2_end;
   logic          per3_end, iter3_end;
   logic [AW-1:0] base2_next, base3_next;

   // step amounts count words, addresses count bytes.
   function automatic logic [AW-1:0] step(
      input logic [AW-1:0] base,
      input logic [AW-1:0] amt
   );
      return base + (amt << addr_stream_pkg::OFFSET_W);
   endfunction

   ////////////////////////////////////////
   // loop limits
   ////////////////////////////////////////
   // a zero count is treated as already finished.
   assign per_end   = (per_q + 1'b1 == cfg_i.lvl[0].period) || (cfg_i.lvl[0].period == '0);
   assign iter_end  = (iter_q + 1'b1 == cfg_i.lvl[0].iterations)
                      || (cfg_i.lvl[0].iterations == '0);
   assign per2_end  = (per2_q + 1'b1 == cfg_i.lvl[1].period) || (cfg_i.lvl[1].period == '0);
   assign iter2_end = (iter2_q + 1'b1 == cfg_i.lvl[1].iterations)
                      || (cfg_i.lvl[1].iterations == '0);
   assign per3_end  = (per3_q + 1'b1 == cfg_i.lvl[2].period) || (cfg_i.lvl[2].period == '0);
   assign iter3_end = (iter3_q + 1'b1 == cfg_i.lvl[2].iterations)
                      || (cfg_i.lvl[2].iterations == '0);

   assign base2_next = step(base2_q, per2_end ? cfg_i.lvl[1].shift : cfg_i.lvl[1].incr);
   assign base3_next = step(base3_q, per3_end ? cfg_i.lvl[2].shift : cfg_i.lvl[2].incr);

   ////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_q <= '0;
         addr_o  <= '0;
         base2_q <= '0;
         base3_q <= '0;
         per_q   <= '0;
         per2_q  <= '0;
         per3_q  <= '0;
         iter_q  <= '0;
         iter2_q <= '0;
         iter3_q <= '0;
         valid_o <= 1'b0;
         done_o  <= 1'b1;
      end else if (run_i) begin
         delay_q <= cfg_i.delay;
         addr_o  <= cfg_i.start;
         base2_q <= cfg_i.start;
         base3_q <= cfg_i.start;
         per_q   <= '0;
         per2_q  <= '0;
         per3_q  <= '0;
         iter_q  <= '0;
         iter2_q <= '0;
         iter3_q <= '0;
         valid_o <= (cfg_i.delay == '0);  // no delay, first address at once.
         done_o  <= 1'b0;
      end else if (delay_q != '0) begin
         delay_q <= delay_q - 1'b1;
         valid_o <= (delay_q == 1);
      end else if (valid_o && ready_i) begin
         if (!per_end) begin
            if (per_q < cfg_i.duty) begin
               addr_o <= step(addr_o, cfg_i.lvl[0].incr);  // inside the duty window.
            end
            per_q <= per_q + 1'b1;
         end else if (!iter_end) begin
            addr_o <= step(addr_o, cfg_i.lvl[0].shift);
            per_q  <= '0;
            iter_q <= iter_q + 1'b1;
         end else if (!(per2_end && iter2_end)) begin
            addr_o  <= base2_next;
            base2_q <= base2_next;
            per_q   <= '0;
            iter_q  <= '0;
            if (!per2_end) begin
               per2_q <= per2_q + 1'b1;
            end else begin
               per2_q  <= '0;
               iter2_q <= iter2_q + 1'b1;
            end
         end else if (!(per3_end && iter3_end)) begin
            // the level-2 base restarts from the new level-3 base.
            addr_o  <= base3_next;
            base2_q <= base3_next;
            base3_q <= base3_next;
            per_q   <= '0;
            iter_q  <= '0;
            per2_q  <= '0;
            iter2_q <= '0;
            if (!per3_end) begin
               per3_q <= per3_q + 1'b1;
            end else begin
               per3_q  <= '0;
               iter3_q <= iter3_q + 1'b1;
            end
         end else begin
            valid_o <= 1'b0;  // last address taken.
            done_o  <= 1'b1;
         end
      end
   end

endmodule

// File: stream_reader.sv
module stream_reader (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                addr_valid_i,
   output logic                                addr_ready_o,
   input  logic [addr_stream_pkg::ADDR_W-1:0]  addr_i,
   output addr_stream_pkg::wb_req_t            wb_req_o,
   input  addr_stream_pkg::wb_rsp_t            wb_rsp_i,
   output logic                                data_valid_o,
   input  logic                                data_ready_i,
   output logic [addr_stream_pkg::DATA_W-1:0]  data_o
);

   localparam logic [1:0] S_IDLE = 2'd0;  // waiting for an address.
   localparam logic [1:0] S_BUS  = 2'd1;  // read on the bus.
   localparam logic [1:0] S_HOLD = 2'd2;  // word waits for the consumer.

   logic [1:0]                        state_q;
   logic [addr_stream_pkg::ADDR_W-1:0] adr_q;
   logic [addr_stream_pkg::DATA_W-1:0] data_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE:  if (addr_valid_i) state_q <= S_BUS;
            S_BUS:   if (wb_rsp_i.ack) state_q <= S_HOLD;
            S_HOLD:  if (data_ready_i) state_q <= S_IDLE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && addr_valid_i) begin
         adr_q <= addr_i;
      end
      if (state_q == S_BUS && wb_rsp_i.ack) begin
         data_q <= wb_rsp_i.dat;
      end
   end

   always_comb begin
      wb_req_o     = '0;  // read only, we and dat stay low.
      wb_req_o.cyc = (state_q == S_BUS);
      wb_req_o.stb = (state_q == S_BUS);
      wb_req_o.adr = adr_q;
   end

   assign addr_ready_o = (state_q == S_IDLE);
   assign data_valid_o = (state_q == S_HOLD);
   assign data_o       = data_q;

endmodule

// File: wb_arbiter.sv
module wb_arbiter #(
   parameter int N_MASTERS = 3
) (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  addr_stream_pkg::wb_req_t  m_req_i [N_MASTERS],
   output addr_stream_pkg::wb_rsp_t  m_rsp_o [N_MASTERS],
   output addr_stream_pkg::wb_req_t  s_req_o,
   input  addr_stream_pkg::wb_rsp_t  s_rsp_i
);

   localparam int GNT_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

   logic [GNT_W-1:0] gnt_q;  // current bus owner.
   logic [GNT_W-1:0] gnt_d;

   ////////////////////////////////////////
   // round-robin grant
   ////////////////////////////////////////
   // scan from the farthest master back, so the nearest requester wins.
   always_comb begin
      int cand;
      gnt_d = gnt_q;
      cand  = 0;
      if (!m_req_i[gnt_q].cyc) begin
         for (int k = N_MASTERS - 1; k > 0; k--) begin
            cand = (int'(gnt_q) + k) % N_MASTERS;
            if (m_req_i[cand].cyc) begin
               gnt_d = GNT_W'(cand);
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         gnt_q <= '0;
      end else begin
         gnt_q <= gnt_d;  // moves only while the owner is off the bus.
      end
   end

   ////////////////////////////////////////
   // request and response routing
   ////////////////////////////////////////
   assign s_req_o = m_req_i[gnt_q];

   always_comb begin
      for (int i = 0; i < N_MASTERS; i++) begin
         m_rsp_o[i] = '0;  // others see no ack.
         if (gnt_q == GNT_W'(i)) begin
            m_rsp_o[i] = s_rsp_i;
         end
      end
   end

endmodule

// File: wb_sram.sv
module wb_sram #(
   parameter int DEPTH = 256
) (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  addr_stream_pkg::wb_req_t  wb_req_i,
   output addr_stream_pkg::wb_rsp_t  wb_rsp_o
);

   localparam int IDX_W = $clog2(DEPTH);
   localparam int LSB   = addr_stream_pkg::OFFSET_W;

   logic [addr_stream_pkg::DATA_W-1:0] mem [DEPTH];
   logic [addr_stream_pkg::DATA_W-1:0] rd_q;
   logic                               ack_q;
   logic [IDX_W-1:0]                   idx;
   logic                               access;

   assign idx    = wb_req_i.adr[LSB +: IDX_W];  // word index.
   assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;  // single cycle ack.
      end
   end

   always_ff @(posedge clk_i) begin
      if (access && wb_req_i.we) begin
         mem[idx] <= wb_req_i.dat;
      end
      rd_q <= mem[idx];
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rd_q;

endmodule

// File: addr_stream_top.sv
module addr_stream_top #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  addr_stream_pkg::wb_req_t            host_req_i,
   output addr_stream_pkg::wb_rsp_t            host_rsp_o,
   input  addr_stream_pkg::gen_cfg_t           cfg_i        [addr_stream_pkg::N_CH],
   input  logic [addr_stream_pkg::N_CH-1:0]    run_i,
   output logic [addr_stream_pkg::N_CH-1:0]    data_valid_o,
   input  logic [addr_stream_pkg::N_CH-1:0]    data_ready_i,
   output logic [addr_stream_pkg::DATA_W-1:0]  data_o       [addr_stream_pkg::N_CH],
   output logic [addr_stream_pkg::N_CH-1:0]    done_o
);

   localparam int N_CH      = addr_stream_pkg::N_CH;
   localparam int N_MASTERS = N_CH + 1;  // channels first, host last.

   addr_stream_pkg::wb_req_t m_req [N_MASTERS];
   addr_stream_pkg::wb_rsp_t m_rsp [N_MASTERS];
   addr_stream_pkg::wb_req_t s_req;
   addr_stream_pkg::wb_rsp_t s_rsp;

   logic [N_CH-1:0]                   ag_valid;
   logic [N_CH-1:0]                   ag_ready;
   logic [addr_stream_pkg::ADDR_W-1:0] ag_addr [N_CH];

   ////////////////////////////////////////
   // stream channels
   ////////////////////////////////////////
   for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
      addr_gen u_gen (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .run_i   (run_i[ch]),
         .cfg_i   (cfg_i[ch]),
         .valid_o (ag_valid[ch]),
         .ready_i (ag_ready[ch]),
         .addr_o  (ag_addr[ch]),
         .done_o  (done_o[ch])
      );

      stream_reader u_rd (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .addr_valid_i (ag_valid[ch]),
         .addr_ready_o (ag_ready[ch]),
         .addr_i       (ag_addr[ch]),
         .wb_req_o     (m_req[ch]),
         .wb_rsp_i     (m_rsp[ch]),
         .data_valid_o (data_valid_o[ch]),
         .data_ready_i (data_ready_i[ch]),
         .data_o       (data_o[ch])
      );
   end

   ////////////////////////////////////////
   // shared bus and memory
   ////////////////////////////////////////
   assign m_req[N_CH] = host_req_i;
   assign host_rsp_o  = m_rsp[N_CH];

   wb_arbiter #(.N_MASTERS(N_MASTERS)) u_arb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   wb_sram #(.DEPTH(MEM_DEPTH)) u_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (s_req),
      .wb_rsp_o (s_rsp)
   );

endmodule

// File: addr_stream_chk.sv
module addr_stream_chk (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  addr_stream_pkg::wb_req_t            s_req_i,
   input  addr_stream_pkg::wb_rsp_t            s_rsp_i,
   input  logic [addr_stream_pkg::N_CH-1:0]    data_valid_i,
   input  logic [addr_stream_pkg::N_CH-1:0]    data_ready_i,
   input  logic [addr_stream_pkg::DATA_W-1:0]  data_i       [addr_stream_pkg::N_CH]
);

   // one owner keeps the bus until the memory answers.
   a_one_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      (s_req_i.cyc && s_req_i.stb && !s_rsp_i.ack) |=> $stable(s_req_i))
      else $error("bus request changed hands before its ack");

   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      s_rsp_i.ack |-> (s_req_i.cyc && s_req_i.stb))
      else $error("ack outside an active bus cycle");

   for (genvar ch = 0; ch < addr_stream_pkg::N_CH; ch++) begin : g_hold
      a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
         (data_valid_i[ch] && !data_ready_i[ch]) |=> (data_valid_i[ch] && $stable(data_i[ch])))
         else $error("stream word on channel %0d changed before it was taken", ch);
   end

endmodule

bind addr_stream_top addr_stream_chk u_chk (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .s_req_i      (s_req),
   .s_rsp_i      (s_rsp),
   .data_valid_i (data_valid_o),
   .data_ready_i (data_ready_i),
   .data_i       (data_o)
);

// File: tb_addr_stream.sv
module tb_addr_stream;

   localparam int N_CH      = addr_stream_pkg::N_CH;
   localparam int N_TESTS   = 5;
   localparam int MAX_ITEMS = 256;

   logic                               clk_i;
   logic                               rst_i;
   addr_stream_pkg::wb_req_t           host_req_i;
   addr_stream_pkg::wb_rsp_t           host_rsp_o;
   addr_stream_pkg::gen_cfg_t          cfg_i [N_CH];
   logic [N_CH-1:0]                    run_i;
   logic [N_CH-1:0]                    data_valid_o;
   logic [N_CH-1:0]                    data_ready_i;
   logic [addr_stream_pkg::DATA_W-1:0] data_o [N_CH];
   logic [N_CH-1:0]                    done_o;

   integer      seed = 93;
   logic [31:0] mem_model [256];  // what the host wrote.
   logic [9:0]  exp_addr [N_CH][MAX_ITEMS];
   int          exp_len [N_CH];

   string                     t_name [N_TESTS];
   addr_stream_pkg::gen_cfg_t t_cfg  [N_TESTS][N_CH];
   logic [N_CH-1:0]           t_run  [N_TESTS];
   logic                      t_bp   [N_TESTS];  // random ready on the streams.
   int                        t_cnt  [N_TESTS][N_CH];

   addr_stream_top #(.MEM_DEPTH(256)) UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "stopped at the first error");
      end
   endtask

   function automatic addr_stream_pkg::loop_cfg_t make_level(input int period, input int incr,
                                                             input int iters, input int shift);
      addr_stream_pkg::loop_cfg_t l;
      l.period     = 8'(period);
      l.incr       = 10'(incr);
      l.iterations = 10'(iters);
      l.shift      = 10'(shift);
      return l;
   endfunction

   function automatic addr_stream_pkg::gen_cfg_t make_cfg(input int start, input int duty,
         input int delay, input addr_stream_pkg::loop_cfg_t l0, l1, l2);
      addr_stream_pkg::gen_cfg_t g;
      g.start  = 10'(start);
      g.duty   = 8'(duty);
      g.delay  = 4'(delay);
      g.lvl[0] = l0;
      g.lvl[1] = l1;
      g.lvl[2] = l2;
      return g;
   endfunction

   function automatic bit at_limit(input int cnt, input int limit);
      return (cnt + 1 == limit) || (limit == 0);  // zero means already finished.
   endfunction

   // expected byte addresses, one per accepted address.
   task automatic model_stream(input int ch, input addr_stream_pkg::gen_cfg_t c);
      logic [9:0] a, b2, b3;
      int         cnt [6];
      int         lim_v [6];
      int         k, n;
      a  = c.start;
      b2 = c.start;
      b3 = c.start;
      n  = 0;
      for (int l = 0; l < 3; l++) begin
         lim_v[2*l]   = int'(c.lvl[l].period);
         lim_v[2*l+1] = int'(c.lvl[l].iterations);
         cnt[2*l]     = 0;
         cnt[2*l+1]   = 0;
      end
      do begin
         exp_addr[ch][n] = a;
         n++;
         k = 0;
         while (k < 6 && at_limit(cnt[k], lim_v[k])) k++;  // first count still running.
         case (k)
            0: if (cnt[0] < int'(c.duty)) begin
               a = a + (c.lvl[0].incr << addr_stream_pkg::OFFSET_W);
            end
            1: a = a + (c.lvl[0].shift << addr_stream_pkg::OFFSET_W);
            2, 3: begin
               b2 = b2 + ((k == 2 ? c.lvl[1].incr : c.lvl[1].shift) << addr_stream_pkg::OFFSET_W);
               a  = b2;
            end
            4, 5: begin
               b3 = b3 + ((k == 4 ? c.lvl[2].incr : c.lvl[2].shift) << addr_stream_pkg::OFFSET_W);
               b2 = b3;
               a  = b3;
            end
            default: ;
         endcase
         for (int j = 0; j < k && k < 6; j++) begin
            cnt[j] = 0;
         end
         if (k < 6) cnt[k]++;
      end while (k < 6 && n < MAX_ITEMS);
      exp_len[ch] = n;
   endtask

   ////////////////////////////////////////
   // bus and stream agents
   ////////////////////////////////////////
   task automatic host_access(input logic we, input int idx, input logic [31:0] wdat,
                              output logic [31:0] rdat);
      addr_stream_pkg::wb_req_t req;
      req     = '0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = 10'(idx << addr_stream_pkg::OFFSET_W);
      req.dat = wdat;
      @(posedge clk_i);
      host_req_i <= req;
      @(negedge clk_i);
      while (!host_rsp_o.ack) @(negedge clk_i);
      rdat = host_rsp_o.dat;
      @(posedge clk_i);
      host_req_i <= '0;  // released the cycle after ack.
   endtask

   task automatic host_check(input int idx, input string tname);
      logic [31:0] rd;
      host_access(1'b0, idx, '0, rd);
      check_val($sformatf("%s host word %0d", tname, idx), mem_model[idx], rd);
   endtask

   task automatic host_traffic(input int n, input string tname);
      for (int i = 0; i < n; i++) begin
         host_check($random(seed) & 255, tname);
         repeat (1 + ($random(seed) & 3)) @(posedge clk_i);
      end
   endtask

   // takes words until the generator is done and the reader stays empty.
   task automatic consume(input int ch, input int n_exp, input logic bp, input string tname);
      int cnt;
      int quiet;
      bit finished;
      cnt      = 0;
      quiet    = 0;
      finished = 0;
      while (!finished) begin
         @(negedge clk_i);
         if (data_valid_o[ch] && data_ready_i[ch]) begin
            if (cnt < exp_len[ch]) begin
               check_val($sformatf("%s ch%0d word %0d", tname, ch, cnt),
                         mem_model[exp_addr[ch][cnt][9:2]], data_o[ch]);
            end
            cnt++;
         end
         quiet    = data_valid_o[ch] ? 0 : quiet + 1;
         finished = done_o[ch] && quiet > 16;
         @(posedge clk_i);
         data_ready_i[ch] <= bp ? 1'($random(seed)) : 1'b1;
      end
      check_val($sformatf("%s ch%0d count", tname, ch), n_exp, cnt);
   endtask

   ////////////////////////////////////////
   // test table
   ////////////////////////////////////////
   task automatic set_row(input int t, input string name, input addr_stream_pkg::gen_cfg_t c0,
         input addr_stream_pkg::gen_cfg_t c1, input logic [1:0] run, input logic bp,
         input int n0, input int n1);
      t_name[t]   = name;
      t_cfg[t][0] = c0;
      t_cfg[t][1] = c1;
      t_run[t]    = run;
      t_bp[t]     = bp;
      t_cnt[t][0] = n0;
      t_cnt[t][1] = n1;
   endtask

   task automatic fill_table();
      set_row(0, "single_level", make_cfg(64, 2, 0, make_level(4, 1, 3, -1), '0, '0), '0,
              2'b01, 1'b0, 12, 0);
      set_row(1, "three_level", '0, make_cfg(256, 2, 0, make_level(2, 1, 2, 3),
              make_level(2, 8, 2, -4), make_level(2, 32, 2, 16)), 2'b10, 1'b0, 0, 64);
      set_row(2, "zero_counts", make_cfg(1020, 0, 5, '0, '0, '0), make_cfg(512, 3, 3,
              make_level(3, 2, 0, 0), make_level(0, 0, 2, 5), '0), 2'b11, 1'b0, 1, 6);
      set_row(3, "dual_backpressure", make_cfg(128, 1, 2, make_level(3, 2, 4, 1), '0, '0),
              make_cfg(768, 1, 1, make_level(2, 1, 3, -2), make_level(3, 4, 2, 8), '0),
              2'b11, 1'b1, 12, 36);
      set_row(4, "restart", make_cfg(64, 2, 2, make_level(4, 1, 3, -1), '0, '0), '0,
              2'b01, 1'b0, 12, 0);
   endtask

   task automatic watchdog();
      int cycles;
      cycles = 10 * (2 * 256 + 20);  // host load, read back and traffic.
      for (int t = 0; t < N_TESTS; t++) begin
         cycles += 200 * (t_cnt[t][0] + t_cnt[t][1]);
      end
      repeat (cycles) @(posedge clk_i);
      $display("timeout, the run did not finish within %0d cycles", cycles);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   endtask

   initial begin
      logic [31:0] rd;
      rst_i        = 1'b1;
      host_req_i   = '0;
      run_i        = '0;
      data_ready_i = '1;
      cfg_i[0]     = '0;
      cfg_i[1]     = '0;
      fill_table();
      fork
         watchdog();
      join_none
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      check_val("reset state", 32'h18, 32'({done_o, data_valid_o, host_rsp_o.ack}));
      @(posedge clk_i);
      rst_i <= 1'b0;

      for (int i = 0; i < 256; i++) begin
         mem_model[i] = $random(seed);
         host_access(1'b1, i, mem_model[i], rd);
      end
      for (int i = 0; i < 256; i++) begin
         host_check(i, "host_rw");
      end

      for (int t = 0; t < N_TESTS; t++) begin
         @(posedge clk_i);
         for (int ch = 0; ch < N_CH; ch++) begin
            model_stream(ch, t_cfg[t][ch]);
            cfg_i[ch] <= t_cfg[t][ch];
         end
         run_i        <= t_run[t];
         data_ready_i <= '1;
         @(posedge clk_i);
         run_i <= '0;
         @(negedge clk_i);
         check_val({t_name[t], " done fall"}, 0, 32'(done_o & t_run[t]));
         fork
            if (t_run[t][0]) consume(0, t_cnt[t][0], t_bp[t], t_name[t]);
            if (t_run[t][1]) consume(1, t_cnt[t][1], t_bp[t], t_name[t]);
            if (t_bp[t]) host_traffic(20, t_name[t]);
         join
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: tb.f
addr_stream_pkg.sv
addr_gen.sv
stream_reader.sv
wb_arbiter.sv
wb_sram.sv
addr_stream_top.sv
addr_stream_chk.sv
tb_addr_stream.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_addr_stream
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
